//--- dot_engine.f
+incdir+include
hdl/dot_engine_pkg.sv
hdl/axil_write_channel.sv
hdl/axil_read_channel.sv
hdl/coef_reg_file.sv
hdl/inner_product_unit.sv
hdl/dot_engine_top.sv
tests/dot_engine_assertions.sv
tests/dot_engine_tb.sv

//--- Bender.yml
package:
  name: dot_engine

export_include_dirs:
  - include

sources:
  # Design sources, package first.
  - files:
      - hdl/dot_engine_pkg.sv
      - hdl/axil_write_channel.sv
      - hdl/axil_read_channel.sv
      - hdl/coef_reg_file.sv
      - hdl/inner_product_unit.sv
      - hdl/dot_engine_top.sv

  # Verification sources.
  - target: test
    files:
      - tests/dot_engine_assertions.sv
      - tests/dot_engine_tb.sv

//--- tests/dot_engine_tb.sv
// --------------------------------------
// Dot engine testbench.
// Register bus tests and inner product checks.
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dot_engine_config.svh"

module dot_engine_tb;

    // Limit sits well above the roughly 400 cycles the tests take.
    localparam int TIMEOUT_CYCLES = 6000;

    logic i_clk;
    logic i_sync_rst;
    dot_engine_pkg::axil_wr_req_t wr_req;
    dot_engine_pkg::axil_wr_rsp_t wr_rsp;
    dot_engine_pkg::axil_rd_req_t rd_req;
    dot_engine_pkg::axil_rd_rsp_t rd_rsp;
    dot_engine_pkg::coef_vec_t vec;
    logic vec_valid;
    dot_engine_pkg::data_word_t in_prod;
    logic in_prod_valid;

    // Shadow copy of the coefficient registers.
    logic [31:0] shadow [4];
    // Expected results with the cycle of their strobe.
    logic [31:0] exp_q [$];
    int unsigned strobe_cyc_q [$];

    int unsigned cycle_cnt = 0;
    int checks = 0;
    int errors = 0;
    int test_num = 0;
    int test_err_base = 0;

    dot_engine_top UUT (
        .i_clk(i_clk),
        .i_sync_rst(i_sync_rst),
        .i_wr_req(wr_req),
        .o_wr_rsp(wr_rsp),
        .i_rd_req(rd_req),
        .o_rd_rsp(rd_rsp),
        .i_vec(vec),
        .i_vec_valid(vec_valid),
        .o_in_prod(in_prod),
        .o_in_prod_valid(in_prod_valid)
    );

    // 20 ns clock.
    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // --------------------------------------
    // Helpers and reference model.
    // Step to 1 ns after the next rising edge.
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Strobed bytes come from the new data.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    // Full-width sum of products, low word kept.
    function automatic logic [31:0] ref_inner_prod(input dot_engine_pkg::coef_vec_t v,
                                                   input dot_engine_pkg::coef_vec_t c);
        logic [63:0] acc;
        acc = 64'd0;
        for (int i = 0; i < 4; i++) begin
            acc = acc + 64'(v[i]) * 64'(c[i]);
        end
        return acc[31:0];
    endfunction

    // --------------------------------------
    // Bus master tasks.
    task automatic start_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        wr_req.awvalid = 1'b1;
        wr_req.awaddr = addr;
        wr_req.wvalid = 1'b1;
        wr_req.wdata = data;
        wr_req.wstrb = strb;
    endtask

    // Valids drop after the edge that moves address and data.
    task automatic wait_write_accept();
        while (!wr_rsp.awready) begin
            next_cycle();
        end
        check_value("wready", wr_rsp.wready, 1'b1);
        next_cycle();
        wr_req.awvalid = 1'b0;
        wr_req.wvalid = 1'b0;
    endtask

    // Bready rises after the given stall.
    task automatic take_write_response(input int stall, output logic [1:0] resp);
        while (!wr_rsp.bvalid) begin
            next_cycle();
        end
        resp = wr_rsp.bresp;
        repeat (stall) next_cycle();
        wr_req.bready = 1'b1;
        next_cycle();
        wr_req.bready = 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [1:0] resp;
        logic in_range;
        in_range = (addr[31:4] == '0);
        start_write(addr, data, strb);
        wait_write_accept();
        take_write_response($urandom_range(0, 3), resp);
        check_value("bresp", resp, in_range ? `DE_RESP_OKAY : `DE_RESP_SLVERR);
        if (in_range) begin
            shadow[addr[3:2]] = merge_bytes(shadow[addr[3:2]], data, strb);
        end
    endtask

    task automatic check_read(input logic [31:0] addr, input logic [31:0] exp_data);
        int stall;
        stall = $urandom_range(0, 3);
        rd_req.arvalid = 1'b1;
        rd_req.araddr = addr;
        while (!rd_rsp.arready) begin
            next_cycle();
        end
        next_cycle();
        rd_req.arvalid = 1'b0;
        while (!rd_rsp.rvalid) begin
            next_cycle();
        end
        check_value("rdata", rd_rsp.rdata, exp_data);
        check_value("rresp", rd_rsp.rresp,
                    (addr[31:4] == '0) ? `DE_RESP_OKAY : `DE_RESP_SLVERR);
        // Rready rises after a random stall, read data must hold meanwhile.
        repeat (stall) next_cycle();
        rd_req.rready = 1'b1;
        next_cycle();
        rd_req.rready = 1'b0;
    endtask

    task automatic finish_test(input string name);
        test_num++;
        $display("Test %0d %s: %0d errors", test_num, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    // --------------------------------------
    // Result comparison against the model.
    always @(posedge i_clk) begin
        if (vec_valid) begin
            exp_q.push_back(ref_inner_prod(vec, {shadow[3], shadow[2], shadow[1], shadow[0]}));
            strobe_cyc_q.push_back(cycle_cnt);
        end
        if (in_prod_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result strobe seen with no input vector outstanding");
            end else begin
                check_value("o_in_prod", in_prod, exp_q.pop_front());
                check_value("o_in_prod_valid latency", cycle_cnt - strobe_cyc_q.pop_front(), 2);
            end
        end
    end

    // Run limit.
    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // --------------------------------------
    // Test sequence.
    initial begin : main_seq
        logic [31:0] data;
        logic [31:0] addr;
        logic [1:0] resp;
        int gap;
        void'($urandom(32'h534c_0a7b));
        i_sync_rst = 1'b1;
        wr_req = '0;
        rd_req = '0;
        vec = '0;
        vec_valid = 1'b0;
        for (int i = 0; i < 4; i++) begin
            shadow[i] = '0;
        end
        repeat (10) @(posedge i_clk);
        #1;
        i_sync_rst = 1'b0;

        // Outputs idle and registers clear.
        check_value("awready", wr_rsp.awready, 1'b0);
        check_value("wready", wr_rsp.wready, 1'b0);
        check_value("bvalid", wr_rsp.bvalid, 1'b0);
        check_value("arready", rd_rsp.arready, 1'b0);
        check_value("rvalid", rd_rsp.rvalid, 1'b0);
        check_value("o_in_prod_valid", in_prod_valid, 1'b0);
        for (int i = 0; i < 4; i++) begin
            check_read(32'(i * 4), 32'd0);
        end
        finish_test("reset state");

        for (int i = 0; i < 4; i++) begin
            write_reg(32'(i * 4), $urandom(), 4'hF);
        end
        for (int i = 0; i < 4; i++) begin
            check_read(32'(i * 4), shadow[i]);
        end
        finish_test("full-strobe writes");

        for (int n = 0; n < 12; n++) begin
            write_reg({28'd0, 2'($urandom_range(0, 3)), 2'b00}, $urandom(),
                      4'($urandom_range(1, 14)));
        end
        for (int i = 0; i < 4; i++) begin
            check_read(32'(i * 4), shadow[i]);
        end
        finish_test("partial-strobe writes");

        // Bit 4 forced so the upper field is never zero.
        for (int i = 0; i < 4; i++) begin
            addr = ($urandom() & 32'hFFFF_FFF0) | 32'h0000_0010 | 32'(i * 4);
            write_reg(addr, $urandom(), 4'hF);
            check_read(addr, 32'd0);
        end
        for (int i = 0; i < 4; i++) begin
            check_read(32'(i * 4), shadow[i]);
        end
        finish_test("out-of-range access");

        // Zero gap gives back-to-back strobes.
        for (int n = 0; n < 40; n++) begin
            for (int i = 0; i < 4; i++) begin
                vec[i] = $urandom();
            end
            vec_valid = 1'b1;
            next_cycle();
            vec_valid = 1'b0;
            gap = $urandom_range(0, 2);
            repeat (gap) next_cycle();
        end
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (3) next_cycle();
        finish_test("inner product stream");

        // First response stalled while a second write waits.
        data = $urandom();
        start_write(32'h4, data, 4'hF);
        wait_write_accept();
        while (!wr_rsp.bvalid) begin
            next_cycle();
        end
        shadow[1] = data;
        data = $urandom();
        start_write(32'h8, data, 4'h3);
        repeat (6) begin
            next_cycle();
            check_value("bvalid", wr_rsp.bvalid, 1'b1);
            check_value("awready", wr_rsp.awready, 1'b0);
        end
        check_value("bresp", wr_rsp.bresp, `DE_RESP_OKAY);
        wr_req.bready = 1'b1;
        next_cycle();
        wr_req.bready = 1'b0;
        wait_write_accept();
        take_write_response(0, resp);
        check_value("bresp", resp, `DE_RESP_OKAY);
        shadow[2] = merge_bytes(shadow[2], data, 4'h3);
        check_read(32'h4, shadow[1]);
        check_read(32'h8, shadow[2]);
        finish_test("write response back-pressure");

        $display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/dot_engine_assertions.sv
// --------------------------------------
// Dot engine assertions.
// Handshake and result strobe timing on the top level.
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dot_engine_assertions (
    input wire logic i_clk,
    input wire logic i_sync_rst,
    input wire dot_engine_pkg::axil_wr_req_t i_wr_req,
    input wire dot_engine_pkg::axil_wr_rsp_t o_wr_rsp,
    input wire dot_engine_pkg::axil_rd_req_t i_rd_req,
    input wire dot_engine_pkg::axil_rd_rsp_t o_rd_rsp,
    input wire logic i_vec_valid,
    input wire logic o_in_prod_valid
);

    // --------------------------------------
    // Bus handshakes.
    // Address ready is a single-cycle pulse.
    awready_pulse: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        o_wr_rsp.awready |=> !o_wr_rsp.awready)
        else $error("awready high for more than one cycle");

    // Write response held until the master takes it.
    bvalid_hold: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        o_wr_rsp.bvalid && !i_wr_req.bready |=> o_wr_rsp.bvalid)
        else $error("bvalid dropped without bready");

    // Read data held stable under back-pressure.
    rdata_hold: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        o_rd_rsp.rvalid && !i_rd_req.rready |=> o_rd_rsp.rvalid && $stable(o_rd_rsp.rdata))
        else $error("rvalid or rdata changed without rready");

    // --------------------------------------
    // Stream timing.
    // Each input strobe gives a result two edges later.
    prod_follows: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        i_vec_valid |-> ##2 o_in_prod_valid)
        else $error("result strobe missing after input strobe");

    // No result without a matching input strobe.
    prod_origin: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        o_in_prod_valid |-> $past(i_vec_valid, 2))
        else $error("result strobe without input strobe");

endmodule

bind dot_engine_top dot_engine_assertions u_assertions (
    .i_clk(i_clk),
    .i_sync_rst(i_sync_rst),
    .i_wr_req(i_wr_req),
    .o_wr_rsp(o_wr_rsp),
    .i_rd_req(i_rd_req),
    .o_rd_rsp(o_rd_rsp),
    .i_vec_valid(i_vec_valid),
    .o_in_prod_valid(o_in_prod_valid)
);

`default_nettype wire

//--- hdl/dot_engine_top.sv
// --------------------------------------
// Dot engine top level.
// Bus slave, coefficient registers and inner product unit.
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dot_engine_top (
    input wire logic i_clk,
    input wire logic i_sync_rst,
    input wire dot_engine_pkg::axil_wr_req_t i_wr_req,
    output dot_engine_pkg::axil_wr_rsp_t o_wr_rsp,
    input wire dot_engine_pkg::axil_rd_req_t i_rd_req,
    output dot_engine_pkg::axil_rd_rsp_t o_rd_rsp,
    input wire dot_engine_pkg::coef_vec_t i_vec,
    input wire logic i_vec_valid,
    output dot_engine_pkg::data_word_t o_in_prod,
    output logic o_in_prod_valid
);

    // Register update from the write channel.
    dot_engine_pkg::coef_wr_t w_coef_wr;
    // Current coefficient set.
    dot_engine_pkg::coef_vec_t w_coefs;

    // --------------------------------------
    // Bus side.
    axil_write_channel u_wr_chan (
        .i_clk(i_clk),
        .i_sync_rst(i_sync_rst),
        .i_wr_req(i_wr_req),
        .o_wr_rsp(o_wr_rsp),
        .o_coef_wr(w_coef_wr)
    );

    axil_read_channel u_rd_chan (
        .i_clk(i_clk),
        .i_sync_rst(i_sync_rst),
        .i_rd_req(i_rd_req),
        .o_rd_rsp(o_rd_rsp),
        .i_coefs(w_coefs)
    );

    coef_reg_file u_coef_regs (
        .i_clk(i_clk),
        .i_sync_rst(i_sync_rst),
        .i_coef_wr(w_coef_wr),
        .o_coefs(w_coefs)
    );

    // --------------------------------------
    // Stream side.
    inner_product_unit u_in_prod (
        .i_clk(i_clk),
        .i_sync_rst(i_sync_rst),
        .i_vec(i_vec),
        .i_vec_valid(i_vec_valid),
        .i_coefs(w_coefs),
        .o_in_prod(o_in_prod),
        .o_in_prod_valid(o_in_prod_valid)
    );

endmodule

`default_nettype wire

//--- hdl/inner_product_unit.sv
// --------------------------------------
// Inner product of the input vector and coefficients.
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dot_engine_config.svh"

module inner_product_unit (
    input wire logic i_clk,
    input wire logic i_sync_rst,
    input wire dot_engine_pkg::coef_vec_t i_vec,
    input wire logic i_vec_valid,
    input wire dot_engine_pkg::coef_vec_t i_coefs,
    output dot_engine_pkg::data_word_t o_in_prod,
    output logic o_in_prod_valid
);

    dot_engine_pkg::data_word_t prod_sum;
    // First stage, sum and its strobe.
    dot_engine_pkg::data_word_t r_sum;
    logic r_sum_valid;

    // Products and sum kept to the low 32 bits.
    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < `DE_NUM_COEF; i++) begin
            prod_sum = prod_sum + dot_engine_pkg::data_word_t'(i_vec[i] * i_coefs[i]);
        end
    end

    // Sum uses the coefficients at the strobe edge.
    always_ff @(posedge i_clk) begin
        if (i_vec_valid) begin
            r_sum <= prod_sum;
        end
        if (r_sum_valid) begin
            o_in_prod <= r_sum;
        end
    end

    // Strobe pipeline, two stages deep.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_sum_valid <= 1'b0;
            o_in_prod_valid <= 1'b0;
        end else begin
            r_sum_valid <= i_vec_valid;
            o_in_prod_valid <= r_sum_valid;
        end
    end

endmodule

`default_nettype wire

//--- hdl/coef_reg_file.sv
// --------------------------------------
// Coefficient register file.
// Four words with byte-strobed update.
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dot_engine_config.svh"

module coef_reg_file (
    input wire logic i_clk,
    input wire logic i_sync_rst,
    input wire dot_engine_pkg::coef_wr_t i_coef_wr,
    output dot_engine_pkg::coef_vec_t o_coefs
);

    // The four coefficients, cleared at reset.
    dot_engine_pkg::coef_vec_t r_coefs;

    // Merged word for the indexed register.
    dot_engine_pkg::data_word_t merged_word;

    // --------------------------------------
    // Byte merge.
    // Strobed bytes come from the update, the rest stay.
    always_comb begin
        merged_word = r_coefs[i_coef_wr.idx];
        for (int b = 0; b < `DE_STRB_W; b++) begin
            if (i_coef_wr.strb[b]) begin
                merged_word[b*8 +: 8] = i_coef_wr.data[b*8 +: 8];
            end
        end
    end

    // --------------------------------------
    // Storage.
    // Range is checked upstream, enable is trusted.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_coefs <= '0;
        end else if (i_coef_wr.en) begin
            r_coefs[i_coef_wr.idx] <= merged_word;
        end
    end

    // Whole set goes to readback and the datapath.
    assign o_coefs = r_coefs;

endmodule

`default_nettype wire

//--- hdl/axil_read_channel.sv
// --------------------------------------
// Read channel of the slave bus.
// Returns the addressed coefficient and holds it until taken.
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dot_engine_config.svh"

module axil_read_channel (
    input wire logic i_clk,
    input wire logic i_sync_rst,
    input wire dot_engine_pkg::axil_rd_req_t i_rd_req,
    output dot_engine_pkg::axil_rd_rsp_t o_rd_rsp,
    input wire dot_engine_pkg::coef_vec_t i_coefs
);

    // Control state.
    logic r_arready;
    // Address latched, data due next edge.
    logic r_rd_pend;
    logic r_rvalid;

    // Held read data and response.
    dot_engine_pkg::data_word_t r_rdata;
    logic [1:0] r_rresp;

    // Latched read address, no reset.
    dot_engine_pkg::axil_addr_u r_araddr;

    logic rd_accept;
    logic rd_xfer;
    logic rd_in_range;

    // Only one read in flight, nothing new while data waits.
    assign rd_accept = i_rd_req.arvalid && !r_arready && !r_rd_pend && !r_rvalid;
    assign rd_xfer = r_arready && i_rd_req.arvalid;
    assign rd_in_range = (r_araddr.fields.upper == '0);

    // --------------------------------------
    // Handshake and data FSM.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_arready <= 1'b0;
            r_rd_pend <= 1'b0;
            r_rvalid <= 1'b0;
            r_rdata <= '0;
            r_rresp <= `DE_RESP_OKAY;
        end else begin
            // Single-cycle ready pulse.
            r_arready <= rd_accept;
            r_rd_pend <= rd_xfer;
            if (r_rd_pend) begin
                r_rvalid <= 1'b1;
                // Out of range reads return zero.
                r_rdata <= rd_in_range ? i_coefs[r_araddr.fields.word_idx] : '0;
                r_rresp <= rd_in_range ? `DE_RESP_OKAY : `DE_RESP_SLVERR;
            end else if (r_rvalid && i_rd_req.rready) begin
                r_rvalid <= 1'b0;
            end
        end
    end

    // Address capture at the handshake.
    always_ff @(posedge i_clk) begin
        if (rd_xfer) begin
            r_araddr.raw <= i_rd_req.araddr;
        end
    end

    // Drive the bus response.
    assign o_rd_rsp.arready = r_arready;
    assign o_rd_rsp.rvalid = r_rvalid;
    assign o_rd_rsp.rdata = r_rdata;
    assign o_rd_rsp.rresp = r_rresp;

endmodule

`default_nettype wire

//--- hdl/axil_write_channel.sv
// --------------------------------------
// Write channel of the slave bus.
// Accepts address and data together, issues one register update.
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dot_engine_config.svh"

module axil_write_channel (
    input wire logic i_clk,
    input wire logic i_sync_rst,
    input wire dot_engine_pkg::axil_wr_req_t i_wr_req,
    output dot_engine_pkg::axil_wr_rsp_t o_wr_rsp,
    output dot_engine_pkg::coef_wr_t o_coef_wr
);

    // --------------------------------------
    // Control state.
    // Channel free to take a new write.
    logic r_idle;
    // Drives both awready and wready.
    logic r_addr_rdy;
    // Address and data latched, response due next edge.
    logic r_wr_pend;
    logic r_bvalid;
    logic [1:0] r_bresp;
    // One-cycle register update enable.
    logic r_wr_en;

    // Payload, loaded at the handshake.
    dot_engine_pkg::axil_addr_u r_awaddr;
    dot_engine_pkg::data_word_t r_wdata;
    logic [`DE_STRB_W-1:0] r_wstrb;
    logic [`DE_WORD_IDX_W-1:0] r_wr_idx;

    logic wr_accept;
    logic wr_xfer;
    logic wr_in_range;

    // Both valids must be present before the slave offers ready.
    assign wr_accept = r_idle && i_wr_req.awvalid && i_wr_req.wvalid;
    // Address and data move on the same edge.
    assign wr_xfer = r_addr_rdy && i_wr_req.awvalid && i_wr_req.wvalid;
    // Any set bit above the word index is out of range.
    assign wr_in_range = (r_awaddr.fields.upper == '0);

    // --------------------------------------
    // Handshake and response FSM.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_idle <= 1'b1;
            r_addr_rdy <= 1'b0;
            r_wr_pend <= 1'b0;
            r_bvalid <= 1'b0;
            r_bresp <= `DE_RESP_OKAY;
            r_wr_en <= 1'b0;
        end else begin
            // Ready is a single-cycle pulse.
            r_addr_rdy <= wr_accept;
            r_wr_pend <= wr_xfer;
            // Update only for an address inside the map.
            r_wr_en <= r_wr_pend && wr_in_range;
            if (wr_accept) begin
                r_idle <= 1'b0;
            end
            if (r_wr_pend) begin
                r_bvalid <= 1'b1;
                r_bresp <= wr_in_range ? `DE_RESP_OKAY : `DE_RESP_SLVERR;
            end else if (r_bvalid && i_wr_req.bready) begin
                // Response taken, channel free again.
                r_bvalid <= 1'b0;
                r_idle <= 1'b1;
            end
        end
    end

    // --------------------------------------
    // Payload capture.
    always_ff @(posedge i_clk) begin
        if (wr_xfer) begin
            r_awaddr.raw <= i_wr_req.awaddr;
            r_wdata <= i_wr_req.wdata;
            r_wstrb <= i_wr_req.wstrb;
        end
        // Index is taken from the decoded view.
        if (r_wr_pend) begin
            r_wr_idx <= r_awaddr.fields.word_idx;
        end
    end

    // Drive the bus response.
    assign o_wr_rsp.awready = r_addr_rdy;
    assign o_wr_rsp.wready = r_addr_rdy;
    assign o_wr_rsp.bvalid = r_bvalid;
    assign o_wr_rsp.bresp = r_bresp;

    // Drive the register update.
    assign o_coef_wr.en = r_wr_en;
    assign o_coef_wr.idx = r_wr_idx;
    assign o_coef_wr.data = r_wdata;
    assign o_coef_wr.strb = r_wstrb;

endmodule

`default_nettype wire

//--- hdl/dot_engine_pkg.sv
// --------------------------------------
// Dot engine types.
// Bus structs, address union and coefficient types.
// --------------------------------------
`default_nettype none

`include "dot_engine_config.svh"

package dot_engine_pkg;

    // One data word, also one coefficient.
    typedef logic [`DE_DATA_W-1:0] data_word_t;

    // Coefficient set or input vector, element 0 at the low end.
    typedef data_word_t [`DE_NUM_COEF-1:0] coef_vec_t;

    // Address split into upper bits, register index and byte offset.
    typedef struct packed {
        logic [`DE_ADDR_W-`DE_WORD_IDX_W-`DE_BYTE_OFF_W-1:0] upper;
        logic [`DE_WORD_IDX_W-1:0] word_idx;
        logic [`DE_BYTE_OFF_W-1:0] byte_off;
    } axil_addr_fields_t;

    // Same address word, plain or decoded.
    typedef union packed {
        logic [`DE_ADDR_W-1:0] raw;
        axil_addr_fields_t fields;
    } axil_addr_u;

    // --------------------------------------
    // Write side, master to slave.
    typedef struct packed {
        logic awvalid;
        logic [`DE_ADDR_W-1:0] awaddr;
        logic wvalid;
        data_word_t wdata;
        logic [`DE_STRB_W-1:0] wstrb;
        logic bready;
    } axil_wr_req_t;

    // Write side, slave to master.
    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
    } axil_wr_rsp_t;

    // Read side, master to slave.
    typedef struct packed {
        logic arvalid;
        logic [`DE_ADDR_W-1:0] araddr;
        logic rready;
    } axil_rd_req_t;

    // Read side, slave to master.
    typedef struct packed {
        logic arready;
        logic rvalid;
        data_word_t rdata;
        logic [1:0] rresp;
    } axil_rd_rsp_t;

    // One byte-strobed register update.
    typedef struct packed {
        logic en;
        logic [`DE_WORD_IDX_W-1:0] idx;
        data_word_t data;
        logic [`DE_STRB_W-1:0] strb;
    } coef_wr_t;

endpackage

`default_nettype wire

//--- include/dot_engine_config.svh
// --------------------------------------
// Dot engine configuration.
// Bus widths, register count and response codes.
// --------------------------------------
`ifndef DOT_ENGINE_CONFIG_SVH
`define DOT_ENGINE_CONFIG_SVH

// --------------------------------------
// Bus widths.
// Address width of the slave bus.
`define DE_ADDR_W 32
// Data and coefficient width.
`define DE_DATA_W 32
// One strobe bit per data byte.
`define DE_STRB_W 4

// --------------------------------------
// Register map.
// Number of coefficient registers.
`define DE_NUM_COEF 4
// Register index bits in the address.
`define DE_WORD_IDX_W 2
// Byte offset bits below the index.
`define DE_BYTE_OFF_W 2

// --------------------------------------
// Response codes.
`define DE_RESP_OKAY 2'b00
`define DE_RESP_SLVERR 2'b10

`endif
